// ==== common/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

   ////////////////////////////////////////
   // Widths
   ////////////////////////////////////////
   localparam int ADDR_W     = 16;          // Byte address
   localparam int DATA_W     = 32;          // One word per line at every level
   localparam int STRB_W     = DATA_W/8;    // One enable per byte
   localparam int WORD_OFF_W = 2;           // Byte offset inside a word

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [STRB_W-1:0] strb_t;       // All zeros means read

   ////////////////////////////////////////
   // Requests
   ////////////////////////////////////////
   // L1 -> arbiter -> L2 -> memory
   typedef struct packed {
      addr_t addr;
      data_t wdata;
      strb_t wstrb;
   } mem_req_t;

   // CPU port, instr picks the L1
   typedef struct packed {
      logic  instr;
      addr_t addr;
      data_t wdata;
      strb_t wstrb;
   } cpu_req_t;

   // Byte merge of a write into a stored word, shared by dcache and L2
   function automatic data_t merge_bytes(data_t old_w, data_t new_w, strb_t strb);
      data_t res;
      res = old_w;
      for (int b = 0; b < STRB_W; b++)
      begin
         if (strb[b])
            res[8*b +: 8] = new_w[8*b +: 8];   // Strobed byte wins
      end
      return res;
   endfunction

endpackage

`default_nettype wire

// ==== l1_cache/l1_icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1_icache #(
   parameter int L1_INDEX_W = 3
) (
   input  wire                       i_clk,
   input  wire                       i_rst_n,
   // CPU side
   input  wire                       i_valid,
   input  wire  cache_pkg::addr_t    i_addr,
   output logic                      o_ready,
   output cache_pkg::data_t          o_rdata,
   // Back-end toward the arbiter
   output logic                      o_be_valid,
   output cache_pkg::addr_t          o_be_addr,
   input  wire                       i_be_ready,
   input  wire  cache_pkg::data_t    i_be_rdata
);

   localparam int TAG_W = cache_pkg::ADDR_W - cache_pkg::WORD_OFF_W - L1_INDEX_W;
   localparam int LINES = 2**L1_INDEX_W;

   logic [LINES-1:0]        line_vld;          // Valid bit per line
   logic [TAG_W-1:0]        tag_mem  [LINES];
   cache_pkg::data_t        data_mem [LINES];

   logic [L1_INDEX_W-1:0]   idx;
   logic [TAG_W-1:0]        tag;
   logic                    hit;
   logic                    start;             // Fresh request this cycle
   logic                    fill;              // Back-end word arrives

   assign idx   = i_addr[cache_pkg::WORD_OFF_W +: L1_INDEX_W];
   assign tag   = i_addr[cache_pkg::ADDR_W-1 -: TAG_W];
   assign hit   = line_vld[idx] && (tag_mem[idx] == tag);
   assign start = i_valid && !o_ready && !o_be_valid;   // CPU holds valid through o_ready
   assign fill  = o_be_valid && i_be_ready;

   // Word aligned fetch address, CPU keeps it stable
   assign o_be_addr = {i_addr[cache_pkg::ADDR_W-1:cache_pkg::WORD_OFF_W],
                       {cache_pkg::WORD_OFF_W{1'b0}}};

   ////////////////////////////////////////
   // Control
   ////////////////////////////////////////
   always_ff @(posedge i_clk or negedge i_rst_n)
   begin
      if (!i_rst_n)
      begin
         o_ready    <= 1'b0;
         o_be_valid <= 1'b0;
         line_vld   <= '0;
      end
      else
      begin
         o_ready <= 1'b0;                     // One-cycle pulse
         if (start && hit)
            o_ready <= 1'b1;                  // Hit answers next cycle
         else if (start)
            o_be_valid <= 1'b1;               // Miss, go to L2
         if (fill)
         begin
            o_be_valid    <= 1'b0;
            o_ready       <= 1'b1;
            line_vld[idx] <= 1'b1;
         end
      end
   end

   // Line arrays and answer word
   always_ff @(posedge i_clk)
   begin
      if (start && hit)
         o_rdata <= data_mem[idx];
      if (fill)
      begin
         o_rdata       <= i_be_rdata;         // Forward the fetched word
         tag_mem[idx]  <= tag;
         data_mem[idx] <= i_be_rdata;
      end
   end

endmodule

`default_nettype wire

// ==== l1_cache/l1_dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1_dcache #(
   parameter int L1_INDEX_W = 3
) (
   input  wire                          i_clk,
   input  wire                          i_rst_n,
   // CPU side
   input  wire                          i_valid,
   input  wire  cache_pkg::mem_req_t    i_req,
   output logic                         o_ready,
   output cache_pkg::data_t             o_rdata,
   // Back-end toward the arbiter
   output logic                         o_be_valid,
   output cache_pkg::mem_req_t          o_be_req,
   input  wire                          i_be_ready,
   input  wire  cache_pkg::data_t       i_be_rdata
);

   localparam int TAG_W = cache_pkg::ADDR_W - cache_pkg::WORD_OFF_W - L1_INDEX_W;
   localparam int LINES = 2**L1_INDEX_W;

   logic [LINES-1:0]        line_vld;
   logic [TAG_W-1:0]        tag_mem  [LINES];
   cache_pkg::data_t        data_mem [LINES];

   logic [L1_INDEX_W-1:0]   idx;
   logic [TAG_W-1:0]        tag;
   logic                    hit;
   logic                    wr;                 // Any strobe set
   logic                    start;
   logic                    done;               // Back-end ready for us
   cache_pkg::addr_t        be_addr;

   assign idx   = i_req.addr[cache_pkg::WORD_OFF_W +: L1_INDEX_W];
   assign tag   = i_req.addr[cache_pkg::ADDR_W-1 -: TAG_W];
   assign hit   = line_vld[idx] && (tag_mem[idx] == tag);
   assign wr    = |i_req.wstrb;
   assign start = i_valid && !o_ready && !o_be_valid;
   assign done  = o_be_valid && i_be_ready;

   // Writes go through unchanged, reads carry zero strobes already
   assign be_addr  = {i_req.addr[cache_pkg::ADDR_W-1:cache_pkg::WORD_OFF_W],
                      {cache_pkg::WORD_OFF_W{1'b0}}};
   assign o_be_req = '{addr: be_addr, wdata: i_req.wdata, wstrb: i_req.wstrb};

   ////////////////////////////////////////
   // Control
   ////////////////////////////////////////
   always_ff @(posedge i_clk or negedge i_rst_n)
   begin
      if (!i_rst_n)
      begin
         o_ready    <= 1'b0;
         o_be_valid <= 1'b0;
         line_vld   <= '0;
      end
      else
      begin
         o_ready <= 1'b0;
         if (start && hit && !wr)
            o_ready <= 1'b1;                    // Read hit
         else if (start)
            o_be_valid <= 1'b1;                 // Read miss or any write
         if (done)
         begin
            o_be_valid <= 1'b0;
            o_ready    <= 1'b1;                 // CPU sees the write only now
            if (!wr)
               line_vld[idx] <= 1'b1;           // No allocate on write miss
         end
      end
   end

   // Line arrays and answer word
   always_ff @(posedge i_clk)
   begin
      if (start && hit && !wr)
         o_rdata <= data_mem[idx];
      if (done)
      begin
         o_rdata <= i_be_rdata;
         if (wr && hit)
            data_mem[idx] <= cache_pkg::merge_bytes(data_mem[idx], i_req.wdata, i_req.wstrb);
         else if (!wr)
         begin
            tag_mem[idx]  <= tag;               // Refill
            data_mem[idx] <= i_be_rdata;
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/l2_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_arbiter (
   input  wire                          i_clk,
   input  wire                          i_rst_n,
   // Instruction L1 back-end
   input  wire                          i_i_valid,
   input  wire  cache_pkg::mem_req_t    i_i_req,
   output logic                         o_i_ready,
   // Data L1 back-end
   input  wire                          i_d_valid,
   input  wire  cache_pkg::mem_req_t    i_d_req,
   output logic                         o_d_ready,
   output cache_pkg::data_t             o_rdata,    // Both L1s read it
   // L2 front-end
   output logic                         o_valid,
   output cache_pkg::mem_req_t          o_req,
   input  wire                          i_ready,
   input  wire  cache_pkg::data_t       i_rdata
);

   logic busy;     // Grant held until the L2 answers
   logic own_i;    // Owner, 1 for instruction side

   ////////////////////////////////////////
   // Grant
   ////////////////////////////////////////
   always_ff @(posedge i_clk or negedge i_rst_n)
   begin
      if (!i_rst_n)
      begin
         busy  <= 1'b0;
         own_i <= 1'b0;
      end
      else if (!busy)
      begin
         if (i_i_valid || i_d_valid)
         begin
            busy  <= 1'b1;
            own_i <= i_i_valid;          // Instruction side wins a tie
         end
      end
      else if (i_ready)
         busy <= 1'b0;                   // Free again after the answer
   end

   // Forward the owner, steer the pulse back to it only
   assign o_valid   = busy && (own_i ? i_i_valid : i_d_valid);
   assign o_req     = own_i ? i_i_req : i_d_req;
   assign o_i_ready = busy && own_i && i_ready;
   assign o_d_ready = busy && !own_i && i_ready;
   assign o_rdata   = i_rdata;

endmodule

`default_nettype wire

// ==== l2_cache/l2_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_cache #(
   parameter int L2_INDEX_W = 5
) (
   input  wire                          i_clk,
   input  wire                          i_rst_n,
   // Front-end from the arbiter
   input  wire                          i_valid,
   input  wire  cache_pkg::mem_req_t    i_req,
   output logic                         o_ready,
   output cache_pkg::data_t             o_rdata,
   // Native memory port
   output logic                         o_mem_valid,
   output cache_pkg::mem_req_t          o_mem_req,
   input  wire                          i_mem_ready,
   input  wire  cache_pkg::data_t       i_mem_rdata
);

   localparam int TAG_W = cache_pkg::ADDR_W - cache_pkg::WORD_OFF_W - L2_INDEX_W;
   localparam int LINES = 2**L2_INDEX_W;

   typedef enum logic [1:0] {
      ST_IDLE,      // Wait for a request, look up
      ST_MEM,       // Memory access in flight
      ST_ANS        // Ready pulse to the arbiter
   } state_t;

   state_t                  state;
   logic [LINES-1:0]        line_vld;
   logic [TAG_W-1:0]        tag_mem  [LINES];
   cache_pkg::data_t        data_mem [LINES];

   logic [L2_INDEX_W-1:0]   idx;
   logic [TAG_W-1:0]        tag;
   logic                    hit;
   logic                    wr;
   logic                    accept;
   logic                    mem_done;
   cache_pkg::mem_req_t     mem_req_q;          // Held for the memory port
   cache_pkg::data_t        rdata_q;

   // Requester holds i_req until o_ready, so lookups use it directly
   assign idx      = i_req.addr[cache_pkg::WORD_OFF_W +: L2_INDEX_W];
   assign tag      = i_req.addr[cache_pkg::ADDR_W-1 -: TAG_W];
   assign hit      = line_vld[idx] && (tag_mem[idx] == tag);
   assign wr       = |i_req.wstrb;
   assign accept   = (state == ST_IDLE) && i_valid;
   assign mem_done = (state == ST_MEM) && i_mem_ready;

   assign o_ready     = (state == ST_ANS);
   assign o_rdata     = rdata_q;
   assign o_mem_valid = (state == ST_MEM);
   assign o_mem_req   = mem_req_q;

   ////////////////////////////////////////
   // FSM and valid bits
   ////////////////////////////////////////
   always_ff @(posedge i_clk or negedge i_rst_n)
   begin
      if (!i_rst_n)
      begin
         state    <= ST_IDLE;
         line_vld <= '0;
      end
      else
      begin
         case (state)
            ST_IDLE:
               if (i_valid)
                  state <= (hit && !wr) ? ST_ANS : ST_MEM;   // Writes always go out
            ST_MEM:
               if (i_mem_ready)
               begin
                  state <= ST_ANS;
                  if (!wr)
                     line_vld[idx] <= 1'b1;   // Read miss allocates
               end
            default:
               state <= ST_IDLE;              // ST_ANS lasts one cycle
         endcase
      end
   end

   // Line arrays, memory request and answer word
   always_ff @(posedge i_clk)
   begin
      if (accept)
      begin
         mem_req_q <= i_req;
         rdata_q   <= data_mem[idx];          // Used only on a read hit
      end
      if (mem_done)
      begin
         rdata_q <= i_mem_rdata;
         if (wr && hit)
            data_mem[idx] <= cache_pkg::merge_bytes(data_mem[idx], i_req.wdata, i_req.wstrb);
         else if (!wr)
         begin
            tag_mem[idx]  <= tag;
            data_mem[idx] <= i_mem_rdata;     // Evicts whatever sat here
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/cache_hier_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_hier_top #(
   parameter int L1_INDEX_W = 3,   // 2**L1_INDEX_W lines per L1
   parameter int L2_INDEX_W = 5    // 2**L2_INDEX_W lines in L2
) (
   input  wire                           i_clk,
   input  wire                           i_rst_n,
   // CPU port
   input  wire                           i_valid,
   input  wire  cache_pkg::cpu_req_t     i_req,
   output logic                          o_ready,
   output cache_pkg::data_t              o_rdata,
   // Native memory port
   output logic                          o_mem_valid,
   output cache_pkg::mem_req_t           o_mem_req,
   input  wire                           i_mem_ready,
   input  wire  cache_pkg::data_t        i_mem_rdata
);

   ////////////////////////////////////////
   // Internal links
   ////////////////////////////////////////
   logic                 ic_ready, dc_ready;
   cache_pkg::data_t     ic_rdata, dc_rdata;
   logic                 ic_be_valid, ic_be_ready;
   cache_pkg::addr_t     ic_be_addr;
   cache_pkg::mem_req_t  ic_be_req;       // Fetch widened to a read request
   logic                 dc_be_valid, dc_be_ready;
   cache_pkg::mem_req_t  dc_req, dc_be_req;
   cache_pkg::data_t     be_rdata;        // Arbiter answer, shared by both L1s
   logic                 l2_valid, l2_ready;
   cache_pkg::mem_req_t  l2_req;
   cache_pkg::data_t     l2_rdata;

   // Steering, data answer takes precedence
   assign o_ready   = ic_ready | dc_ready;
   assign o_rdata   = dc_ready ? dc_rdata : ic_rdata;
   assign dc_req    = '{addr: i_req.addr, wdata: i_req.wdata, wstrb: i_req.wstrb};
   assign ic_be_req = '{addr: ic_be_addr, wdata: '0, wstrb: '0};   // Never writes

   l1_icache #(.L1_INDEX_W(L1_INDEX_W)) l1_i_i (
      .i_clk(i_clk), .i_rst_n(i_rst_n),
      .i_valid(i_valid & i_req.instr), .i_addr(i_req.addr),
      .o_ready(ic_ready), .o_rdata(ic_rdata),
      .o_be_valid(ic_be_valid), .o_be_addr(ic_be_addr),
      .i_be_ready(ic_be_ready), .i_be_rdata(be_rdata)
   );

   l1_dcache #(.L1_INDEX_W(L1_INDEX_W)) l1_d_i (
      .i_clk(i_clk), .i_rst_n(i_rst_n),
      .i_valid(i_valid & ~i_req.instr), .i_req(dc_req),
      .o_ready(dc_ready), .o_rdata(dc_rdata),
      .o_be_valid(dc_be_valid), .o_be_req(dc_be_req),
      .i_be_ready(dc_be_ready), .i_be_rdata(be_rdata)
   );

   l2_arbiter arb_i (
      .i_clk(i_clk), .i_rst_n(i_rst_n),
      .i_i_valid(ic_be_valid), .i_i_req(ic_be_req), .o_i_ready(ic_be_ready),
      .i_d_valid(dc_be_valid), .i_d_req(dc_be_req), .o_d_ready(dc_be_ready),
      .o_rdata(be_rdata),
      .o_valid(l2_valid), .o_req(l2_req), .i_ready(l2_ready), .i_rdata(l2_rdata)
   );

   l2_cache #(.L2_INDEX_W(L2_INDEX_W)) l2_i (
      .i_clk(i_clk), .i_rst_n(i_rst_n),
      .i_valid(l2_valid), .i_req(l2_req), .o_ready(l2_ready), .o_rdata(l2_rdata),
      .o_mem_valid(o_mem_valid), .o_mem_req(o_mem_req),
      .i_mem_ready(i_mem_ready), .i_mem_rdata(i_mem_rdata)
   );

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD_NS  = 40,
   parameter int RST_CYCLES = 4
) (
   output logic o_clk,
   output logic o_rst_n
);

   initial
   begin
      o_clk = 1'b0;
      forever #(PERIOD_NS/2) o_clk = ~o_clk;
   end

   // Reset falls just after time zero so the async reset sees a real edge
   initial
   begin
      o_rst_n = 1'b1;
      #1;
      o_rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge o_clk);
      @(negedge o_clk);
      o_rst_n = 1'b1;                 // Release away from the rising edge
   end

endmodule

`default_nettype wire

// ==== bench/cache_hier_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_hier_properties (
   input wire                        i_clk,
   input wire                        i_rst_n,
   input wire                        i_cpu_valid,
   input wire                        i_cpu_ready,
   input wire                        i_mem_valid,
   input wire  cache_pkg::mem_req_t  i_mem_req,
   input wire                        i_mem_ready
);

   int fail_cnt = 0;      // Read by the testbench top at the end

   ////////////////////////////////////////
   // Memory port handshake
   ////////////////////////////////////////
   property p_mem_hold;
      @(posedge i_clk) disable iff (!i_rst_n)
         (i_mem_valid && !i_mem_ready) |=> (i_mem_valid && $stable(i_mem_req));
   endproperty

   a_mem_hold : assert property (p_mem_hold)
   else
   begin
      $error("memory request dropped or changed before its ready");
      fail_cnt++;
   end

   // Quiet outputs while reset is held
   a_reset_quiet : assert property (@(posedge i_clk) !i_rst_n |-> (!i_cpu_ready && !i_mem_valid))
   else
   begin
      $error("CPU ready or memory valid high during reset");
      fail_cnt++;
   end

   ////////////////////////////////////////
   // CPU port
   ////////////////////////////////////////
   a_ready_needs_valid : assert property (
      @(posedge i_clk) disable iff (!i_rst_n) $rose(i_cpu_ready) |-> $past(i_cpu_valid))
   else
   begin
      $error("CPU ready rose without a pending request");
      fail_cnt++;
   end

endmodule

`default_nettype wire

// ==== bench/tb_cache_hier.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cache_hier;

   localparam int N_ACC   = 200;              // Accesses over all tests rounded up
   localparam int ACC_CYC = 20;               // Worst miss plus memory delay and slack
   localparam int MAX_CYC = N_ACC * ACC_CYC;

   logic                  clk, rst_n;
   logic                  valid;
   cache_pkg::cpu_req_t   req;
   logic                  ready;
   cache_pkg::data_t      rdata;
   logic                  mem_valid;
   cache_pkg::mem_req_t   mem_req;
   logic                  mem_ready = 1'b0;
   cache_pkg::data_t      mem_rdata = '0;

   logic [7:0]            mem_bytes [2**cache_pkg::ADDR_W];   // Memory model contents
   logic [7:0]            shadow    [2**cache_pkg::ADDR_W];   // Expected contents
   cache_pkg::mem_req_t   wr_q [$];           // Writes still due at the memory port
   logic                  mem_busy = 1'b0;
   int                    mem_wait = 0;
   int                    mem_acc = 0, wr_seen = 0;
   int                    checks = 0, errors = 0, tests = 0, cyc = 0;
   int                    chk_mark = 0, err_mark = 0;

   tb_clock_gen clk_i (.o_clk(clk), .o_rst_n(rst_n));

   cache_hier_top #(.L1_INDEX_W(3), .L2_INDEX_W(5)) dut_i (
      .i_clk(clk), .i_rst_n(rst_n),
      .i_valid(valid), .i_req(req), .o_ready(ready), .o_rdata(rdata),
      .o_mem_valid(mem_valid), .o_mem_req(mem_req),
      .i_mem_ready(mem_ready), .i_mem_rdata(mem_rdata)
   );

   bind cache_hier_top cache_hier_properties props_i (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_cpu_valid(i_valid), .i_cpu_ready(o_ready),
      .i_mem_valid(o_mem_valid), .i_mem_req(o_mem_req), .i_mem_ready(i_mem_ready)
   );

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////
   function automatic logic [7:0] init_byte(input logic [15:0] a);
      return (a[7:0] + 8'h3c) ^ (a[15:8] * 8'd29);   // Every address bit counts
   endfunction

   function automatic cache_pkg::data_t shadow_word(input cache_pkg::addr_t a);
      cache_pkg::data_t w;
      for (int b = 0; b < cache_pkg::STRB_W; b++)
         w[8*b +: 8] = shadow[a + b];
      return w;
   endfunction

   task automatic compare_word(input cache_pkg::data_t got, input cache_pkg::data_t exp,
                               input string what);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("ERR %0t ns: %s got %08h expected %08h", $time, what, got, exp);
      end
   endtask

   task automatic compare_count(input int got, input int exp, input string what);
      checks++;
      assert (got == exp)
      else
      begin
         errors++;
         $display("ERR %0t ns: %s count %0d expected %0d", $time, what, got, exp);
      end
   endtask

   // One CPU access with reads checked against the shadow word
   task automatic access(input logic instr, input cache_pkg::addr_t a,
                         input cache_pkg::data_t wdata, input cache_pkg::strb_t wstrb);
      cache_pkg::data_t exp;
      @(negedge clk);
      exp = shadow_word(a);
      if (|wstrb)
      begin
         for (int b = 0; b < cache_pkg::STRB_W; b++)
            if (wstrb[b])
               shadow[a + b] = wdata[8*b +: 8];
         wr_q.push_back('{addr: a, wdata: wdata, wstrb: wstrb});
      end
      valid = 1'b1;
      req   = '{instr: instr, addr: a, wdata: wdata, wstrb: wstrb};
      do
         @(negedge clk);
      while (!ready);
      valid = 1'b0;
      if (wstrb == '0)
         compare_word(rdata, exp, $sformatf("%s %04h", instr ? "fetch" : "load", a));
   endtask

   task automatic report_test(input string name);
      $display("test %-18s checks %0d errors %0d", name, checks - chk_mark, errors - err_mark);
      chk_mark = checks;
      err_mark = errors;
      tests++;
   endtask

   ////////////////////////////////////////
   // Memory model
   ////////////////////////////////////////
   always @(negedge clk)
   begin
      cache_pkg::mem_req_t exp_wr;
      if (!rst_n)
      begin
         mem_ready = 1'b0;
         mem_busy  = 1'b0;
      end
      else if (mem_ready)
      begin
         mem_ready = 1'b0;                    // One-cycle pulse
         mem_busy  = 1'b0;
      end
      else if (mem_valid)
      begin
         if (!mem_busy)
         begin
            mem_busy = 1'b1;
            mem_wait = $urandom_range(3, 0);  // 1 to 4 cycles in all
         end
         else if (mem_wait != 0)
            mem_wait--;
         if (mem_wait == 0)
         begin
            mem_acc++;
            if (|mem_req.wstrb)
            begin
               wr_seen++;
               checks++;
               assert (wr_q.size() > 0)
               else
               begin
                  errors++;
                  $display("Unexpected write reached the memory port at %0t ns", $time);
               end
               if (wr_q.size() > 0)
               begin
                  exp_wr = wr_q.pop_front();
                  compare_word(mem_req.addr, exp_wr.addr, "write address");
                  compare_word(mem_req.wdata, exp_wr.wdata, "write data");
                  compare_word(mem_req.wstrb, exp_wr.wstrb, "write strobes");
               end
               for (int b = 0; b < cache_pkg::STRB_W; b++)
                  if (mem_req.wstrb[b])
                     mem_bytes[mem_req.addr + b] = mem_req.wdata[8*b +: 8];
            end
            for (int b = 0; b < cache_pkg::STRB_W; b++)
               mem_rdata[8*b +: 8] = mem_bytes[mem_req.addr + b];
            mem_ready = 1'b1;
         end
      end
   end

   // Run limit
   always @(posedge clk)
   begin
      cyc++;
      if (cyc >= MAX_CYC)
      begin
         $display("Timeout: the tests did not finish within %0d cycles", MAX_CYC);
         $display("Testbench failed");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////
   initial
   begin
      int mark, op, fails;
      cache_pkg::addr_t a;
      void'($urandom(23043));
      valid = 1'b0;
      req   = '0;
      for (int i = 0; i < 2**cache_pkg::ADDR_W; i++)
      begin
         mem_bytes[i] = init_byte(16'(i));
         shadow[i]    = init_byte(16'(i));
      end
      wait (rst_n === 1'b0);
      wait (rst_n === 1'b1);

      // Fresh fetch misses and repeat fetch hits in the instruction L1
      mark = mem_acc;
      access(1'b1, 16'h0100, '0, '0);
      compare_count(mem_acc - mark, 1, "fetch miss memory");
      mark = mem_acc;
      access(1'b1, 16'h0100, '0, '0);
      compare_count(mem_acc - mark, 0, "fetch hit memory");
      report_test("fetch_hit");

      // Strobed writes on a miss and on a hit
      access(1'b0, 16'h0200, 32'hdeadbeef, 4'b0101);
      access(1'b0, 16'h0200, '0, '0);
      access(1'b0, 16'h0204, '0, '0);
      access(1'b0, 16'h0204, 32'h12345678, 4'b1010);
      mark = mem_acc;
      access(1'b0, 16'h0204, '0, '0);
      compare_count(mem_acc - mark, 0, "merged hit memory");
      report_test("write_strobes");

      // Each write reaches memory once
      mark = wr_seen;
      access(1'b0, 16'h0600, 32'h0badf00d, 4'b1111);
      access(1'b0, 16'h0604, 32'hcafe0001, 4'b0011);
      access(1'b0, 16'h0600, 32'h77665544, 4'b1000);
      compare_count(wr_seen - mark, 3, "memory writes");
      compare_count(wr_q.size(), 0, "pending writes");
      report_test("write_through");

      // Data read served by the shared L2 after an instruction fill
      access(1'b1, 16'h0300, '0, '0);
      mark = mem_acc;
      access(1'b0, 16'h0300, '0, '0);
      compare_count(mem_acc - mark, 0, "L2 hit memory");
      report_test("shared_l2");

      // Every read evicts the other line at the same L2 index
      for (int k = 0; k < 6; k++)
      begin
         mark = mem_acc;
         access(1'b0, (k % 2) ? 16'h0480 : 16'h0400, '0, '0);
         compare_count(mem_acc - mark, 1, "refill memory");
      end
      report_test("evict_refill");

      // Random mix with the instruction region kept apart from data writes
      for (int n = 0; n < 150; n++)
      begin
         op = $urandom_range(2, 0);
         if (op == 0)
         begin
            a = cache_pkg::addr_t'(32'h8000 + 4 * $urandom_range(31, 0));
            access(1'b1, a, '0, '0);
         end
         else
         begin
            a = cache_pkg::addr_t'(32'h1000 + 4 * $urandom_range(63, 0));
            if (op == 1)
               access(1'b0, a, '0, '0);
            else
               access(1'b0, a, $urandom(), cache_pkg::strb_t'($urandom_range(15, 1)));
         end
      end
      compare_count(wr_q.size(), 0, "pending writes");
      report_test("random_mix");

      repeat (2) @(negedge clk);             // Let the last property samples settle
      fails = dut_i.props_i.fail_cnt;
      $display("summary: %0d tests, %0d checks, %0d errors, %0d property failures",
               tests, checks, errors, fails);
      if (errors == 0 && fails == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim.f ====
common/cache_pkg.sv
l1_cache/l1_icache.sv
l1_cache/l1_dcache.sv
src/l2_arbiter.sv
l2_cache/l2_cache.sv
src/cache_hier_top.sv
bench/tb_clock_gen.sv
bench/cache_hier_properties.sv
bench/tb_cache_hier.sv

// ==== Bender.yml ====
package:
  name: cache_hier

sources:
  - files:
      - common/cache_pkg.sv
      - l1_cache/l1_icache.sv
      - l1_cache/l1_dcache.sv
      - src/l2_arbiter.sv
      - l2_cache/l2_cache.sv
      - src/cache_hier_top.sv
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/cache_hier_properties.sv
      - bench/tb_cache_hier.sv
